//--- Makefile
# Verilator build and run for the copper testbench

VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP = copper_tb
FILELIST = verilog.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/copper_axil_regs.sv
// ****************************************
// AXI4-Lite slave, one transaction at a time
// master must present AW and W together
// no byte strobes, writes take the whole word
// unmapped addresses read 0 and ignore writes
// ****************************************
`default_nettype none

module copper_axil_regs #(
    parameter int prog_addr_bits = 11
) (
    input  logic clk,
    input  logic reset,
    input  logic [15:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [15:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    output logic enable,
    input  logic waiting,
    input  logic halted,
    input  logic [copper_pkg::y_bits-1:0] raster_y,
    output logic prog_we,
    output logic [prog_addr_bits-1:0] prog_addr,
    output logic [copper_pkg::data_bits-1:0] prog_wdata,
    input  logic [copper_pkg::data_bits-1:0] prog_rdata,
    output logic dreg_we,
    output logic [copper_pkg::reg_addr_bits-1:0] dreg_index,
    output logic [copper_pkg::data_bits-1:0] dreg_wdata,
    input  logic [copper_pkg::data_bits-1:0] dreg_rdata
);
    import copper_pkg::*;

    typedef enum logic [2:0] {
        src_none,
        src_ctrl,
        src_status,
        src_dreg,
        src_prog
    } rd_src_t;

    // window sizes in bytes
    localparam int dreg_span = 4 * (2 ** reg_addr_bits);
    localparam int prog_span = 4 * (2 ** prog_addr_bits);

    logic ready_en;
    logic rd_pend;
    logic idle;
    logic wr_fire;
    logic rd_fire;
    logic [15:0] host_addr;
    logic is_ctrl;
    logic is_status;
    logic is_dreg;
    logic is_prog;
    rd_src_t rd_src;
    logic [31:0] status_word;

    assign idle = ready_en && !bvalid && !rvalid && !rd_pend;
    assign awready = idle;
    assign wready = idle;
    // a write offered in the same cycle goes first
    assign arready = idle && !(awvalid && wvalid);
    assign wr_fire = idle && awvalid && wvalid;
    assign rd_fire = arvalid && arready;

    // RAM and register file share one host address
    assign host_addr = wr_fire ? awaddr : araddr;

    assign is_ctrl = host_addr[15:2] == ctrl_addr[15:2];
    assign is_status = host_addr[15:2] == status_addr[15:2];
    assign is_dreg = host_addr >= dreg_base && 32'(host_addr - dreg_base) < dreg_span;
    assign is_prog = host_addr >= prog_base && 32'(host_addr - prog_base) < prog_span;

    assign prog_addr = host_addr[prog_addr_bits+1:2];
    assign dreg_index = host_addr[reg_addr_bits+1:2];
    assign prog_wdata = wdata[data_bits-1:0];
    assign dreg_wdata = wdata[data_bits-1:0];
    assign prog_we = wr_fire && is_prog;
    assign dreg_we = wr_fire && is_dreg;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_comb begin
        status_word = '0;
        status_word[stat_wait_bit] = waiting;
        status_word[stat_halt_bit] = halted;
        status_word[stat_y_lsb +: y_bits] = raster_y;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_en <= 1'b0;
            enable <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (wr_fire && is_ctrl) begin
                enable <= wdata[0];
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // one cycle for the RAM and register file reads
            rd_pend <= rd_fire;
            if (rd_pend) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read source select, then data steering
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            if (is_ctrl) begin
                rd_src <= src_ctrl;
            end else if (is_status) begin
                rd_src <= src_status;
            end else if (is_dreg) begin
                rd_src <= src_dreg;
            end else if (is_prog) begin
                rd_src <= src_prog;
            end else begin
                rd_src <= src_none;
            end
        end
        if (rd_pend) begin
            case (rd_src)
                src_ctrl: rdata <= 32'(enable);
                src_status: rdata <= status_word;
                src_dreg: rdata <= 32'(dreg_rdata);
                src_prog: rdata <= 32'(prog_rdata);
                default: rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/copper_engine.sv
// ****************************************
// copper program sequencer
// write_reg takes two words, op then data
// halt restarts at address 0 on the next frame
// enable low freezes the program in place
// ****************************************
`default_nettype none

module copper_engine #(
    parameter int prog_addr_bits = 11
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic [copper_pkg::x_bits-1:0] raster_x,
    input  logic [copper_pkg::y_bits-1:0] raster_y,
    input  logic frame_start,
    output logic [prog_addr_bits-1:0] pc,
    input  logic [copper_pkg::data_bits-1:0] prog_word,
    copper_reg_if.copper wr,
    output logic waiting,
    output logic halted
);
    import copper_pkg::*;

    engine_state_t state;
    op_t op;
    logic [x_bits-1:0] target_x;
    logic [y_bits-1:0] target_y;
    logic target_hit;
    logic decode;

    assign op = op_t'(prog_word[data_bits-1 -: 3]);
    assign target_hit = raster_x == target_x && raster_y == target_y;

    // a finished write overlaps the next op decode
    assign decode = enable && (state == st_fetch || (state == st_write && wr.ready));

    assign waiting = state == st_raster_wait;
    assign halted = state == st_halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            state <= st_fetch;
            wr.valid <= 1'b0;
        end else begin
            // pending write completes even while disabled
            if (state == st_write && wr.ready) begin
                wr.valid <= 1'b0;
                state <= st_fetch;
            end

            if (decode) begin
                case (op)
                    op_wait_y: begin
                        pc <= pc + 1'b1;
                        state <= st_raster_wait;
                    end
                    op_write_reg: begin
                        pc <= pc + 1'b1;
                        state <= st_data;
                    end
                    op_halt: begin
                        state <= st_halted;
                    end
                    // set_x and unknown codes
                    default: begin
                        pc <= pc + 1'b1;
                    end
                endcase
            end else if (enable) begin
                case (state)
                    st_data: begin
                        wr.valid <= 1'b1;
                        pc <= pc + 1'b1;
                        state <= st_write;
                    end
                    st_raster_wait: begin
                        if (target_hit) begin
                            state <= st_fetch;
                        end
                    end
                    st_halted: begin
                        if (frame_start) begin
                            pc <= '0;
                            state <= st_fetch;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // operand and write payload capture
    always_ff @(posedge clk) begin
        if (decode && op == op_set_x) begin
            target_x <= prog_word[x_bits-1:0];
        end
        if (decode && op == op_wait_y) begin
            target_y <= prog_word[y_bits-1:0];
        end
        if (decode && op == op_write_reg) begin
            wr.addr <= prog_word[reg_addr_bits-1:0];
        end
        // second word of write_reg is the data
        if (enable && state == st_data) begin
            wr.data <= prog_word;
        end
    end

endmodule

`default_nettype wire

//--- source/copper_pkg.sv
// ****************************************
// shared widths, opcodes and host address map
// program word layout: op in bits 15..13
// host addresses are byte addresses, word stride 4
// ****************************************
`default_nettype none

package copper_pkg;

    // beam and data widths
    localparam int x_bits = 11;
    localparam int y_bits = 10;
    localparam int reg_addr_bits = 6;
    localparam int data_bits = 16;

    // unlisted codes run as no-ops
    typedef enum logic [2:0] {
        op_set_x     = 3'd0,
        op_wait_y    = 3'd1,
        op_write_reg = 3'd2,
        op_halt      = 3'd7
    } op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_data,
        st_write,
        st_raster_wait,
        st_halted
    } engine_state_t;

    // host address map
    localparam logic [15:0] ctrl_addr = 16'h0000;
    localparam logic [15:0] status_addr = 16'h0004;
    localparam logic [15:0] dreg_base = 16'h0100;
    localparam logic [15:0] prog_base = 16'h2000;

    // status word fields
    localparam int stat_wait_bit = 0;
    localparam int stat_halt_bit = 1;
    localparam int stat_y_lsb = 16;

endpackage

`default_nettype wire

//--- source/copper_ram.sv
// ****************************************
// program RAM, contents undefined after power-up
// engine port reads combinationally at pc
// host readback is one cycle late
// ****************************************
`default_nettype none

module copper_ram #(
    parameter int prog_addr_bits = 11
) (
    input  logic clk,
    input  logic host_we,
    input  logic [prog_addr_bits-1:0] host_addr,
    input  logic [copper_pkg::data_bits-1:0] host_wdata,
    output logic [copper_pkg::data_bits-1:0] host_rdata,
    input  logic [prog_addr_bits-1:0] pc,
    output logic [copper_pkg::data_bits-1:0] prog_word
);
    import copper_pkg::*;

    localparam int depth = 2 ** prog_addr_bits;

    logic [data_bits-1:0] mem [depth];

    // host write and registered read share one address
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
    end

    // op at pc is decoded in the same cycle
    assign prog_word = mem[pc];

endmodule

`default_nettype wire

//--- source/copper_reg_if.sv
// ****************************************
// copper to display register write channel
// valid holds with addr and data until ready
// ****************************************
`default_nettype none

interface copper_reg_if;
    import copper_pkg::*;

    logic [reg_addr_bits-1:0] addr;
    logic [data_bits-1:0] data;
    logic valid;
    logic ready;

    modport copper (
        output addr, data, valid,
        input  ready
    );

    modport regfile (
        input  addr, data, valid,
        output ready
    );
endinterface

`default_nettype wire

//--- source/display_reg_file.sv
// ****************************************
// 64 display registers, cleared at reset
// host write wins and drops copper ready
// host readback is one cycle late
// ****************************************
`default_nettype none

module display_reg_file (
    input  logic clk,
    input  logic reset,
    copper_reg_if.regfile wr,
    input  logic host_we,
    input  logic [copper_pkg::reg_addr_bits-1:0] host_index,
    input  logic [copper_pkg::data_bits-1:0] host_wdata,
    output logic [copper_pkg::data_bits-1:0] host_rdata
);
    import copper_pkg::*;

    localparam int reg_count = 2 ** reg_addr_bits;

    logic [data_bits-1:0] regs [reg_count];
    logic copper_write;

    // copper stalls only in host write cycles
    assign wr.ready = !host_we;
    assign copper_write = wr.valid && wr.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (host_we) begin
            regs[host_index] <= host_wdata;
        end else if (copper_write) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // old value if written in the same cycle
    always_ff @(posedge clk) begin
        host_rdata <= regs[host_index];
    end

endmodule

`default_nettype wire

//--- source/raster_counter.sv
// ****************************************
// free-running beam position, no blanking
// h_total and v_total must fit the x and y widths
// ****************************************
`default_nettype none

module raster_counter #(
    parameter int h_total = 64,
    parameter int v_total = 32
) (
    input  logic clk,
    input  logic reset,
    output logic [copper_pkg::x_bits-1:0] raster_x,
    output logic [copper_pkg::y_bits-1:0] raster_y,
    output logic frame_start
);
    import copper_pkg::*;

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = raster_x == x_bits'(h_total - 1);
    assign y_wrap = raster_y == y_bits'(v_total - 1);

    // high for the whole cycle spent at the origin
    assign frame_start = raster_x == '0 && raster_y == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (x_wrap) begin
            raster_x <= '0;
            // next line, or back to the top of the frame
            if (y_wrap) begin
                raster_y <= '0;
            end else begin
                raster_y <= raster_y + 1'b1;
            end
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/vdp_copper_top.sv
// ****************************************
// copper top level, AXI4-Lite host port
// raster totals are small for simulation
// ****************************************
`default_nettype none

module vdp_copper_top #(
    parameter int prog_addr_bits = 11,
    parameter int h_total = 64,
    parameter int v_total = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic [15:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [15:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready
);
    import copper_pkg::*;

    logic [x_bits-1:0] raster_x;
    logic [y_bits-1:0] raster_y;
    logic frame_start;
    logic [prog_addr_bits-1:0] pc;
    logic [data_bits-1:0] prog_word;
    logic enable;
    logic waiting;
    logic halted;
    logic prog_we;
    logic [prog_addr_bits-1:0] prog_addr;
    logic [data_bits-1:0] prog_wdata;
    logic [data_bits-1:0] prog_rdata;
    logic dreg_we;
    logic [reg_addr_bits-1:0] dreg_index;
    logic [data_bits-1:0] dreg_wdata;
    logic [data_bits-1:0] dreg_rdata;

    copper_reg_if reg_wr ();

    raster_counter #(
        .h_total(h_total),
        .v_total(v_total)
    ) raster (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .frame_start(frame_start)
    );

    copper_ram #(
        .prog_addr_bits(prog_addr_bits)
    ) ram (
        .clk(clk),
        .host_we(prog_we),
        .host_addr(prog_addr),
        .host_wdata(prog_wdata),
        .host_rdata(prog_rdata),
        .pc(pc),
        .prog_word(prog_word)
    );

    copper_engine #(
        .prog_addr_bits(prog_addr_bits)
    ) engine (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .frame_start(frame_start),
        .pc(pc),
        .prog_word(prog_word),
        .wr(reg_wr.copper),
        .waiting(waiting),
        .halted(halted)
    );

    display_reg_file dregs (
        .clk(clk),
        .reset(reset),
        .wr(reg_wr.regfile),
        .host_we(dreg_we),
        .host_index(dreg_index),
        .host_wdata(dreg_wdata),
        .host_rdata(dreg_rdata)
    );

    copper_axil_regs #(
        .prog_addr_bits(prog_addr_bits)
    ) host_regs (
        .clk(clk),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .enable(enable),
        .waiting(waiting),
        .halted(halted),
        .raster_y(raster_y),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_wdata(prog_wdata),
        .prog_rdata(prog_rdata),
        .dreg_we(dreg_we),
        .dreg_index(dreg_index),
        .dreg_wdata(dreg_wdata),
        .dreg_rdata(dreg_rdata)
    );

endmodule

`default_nettype wire

//--- test/copper_tb_axil.svh
// ****************************************
// AXI4-Lite master tasks for copper_tb
// one access at a time, AW and W together
// outputs sampled on the falling edge
// ****************************************
`ifndef copper_tb_axil_svh
`define copper_tb_axil_svh

task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    // ready seen at the falling edge, transfer on the next rising edge
    @(negedge clk);
    while (!(awready && wready)) begin
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) begin
        @(negedge clk);
    end
    checks++;
    assert (bresp == 2'b00) else begin
        errors++;
        $display("ERR at %0t: write to %h answered bresp %b", $time, addr, bresp);
    end
    @(posedge clk);
    #2;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) begin
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) begin
        @(negedge clk);
    end
    data = rdata;
    checks++;
    assert (rresp == 2'b00) else begin
        errors++;
        $display("ERR at %0t: read from %h answered rresp %b", $time, addr, rresp);
    end
    @(posedge clk);
    #2;
    rready = 1'b0;
endtask

`endif

//--- test/copper_tb.sv
// ****************************************
// testbench for vdp_copper_top
// table of AXI4-Lite accesses and raster waits
// raster totals must match the DUT parameters
// ****************************************
`default_nettype none

module copper_tb;
    import copper_pkg::*;

    localparam int h_total = 64;
    localparam int v_total = 32;
    localparam int frame_cycles = h_total * v_total;
    localparam int reset_cycles = 5;
    localparam logic [31:0] full_mask = 32'hffff_ffff;

    localparam logic [1:0] k_write = 2'd0;
    localparam logic [1:0] k_check = 2'd1;
    localparam logic [1:0] k_wait_y = 2'd2;

    // check uses data as a mask, wait uses data and exp as y bounds
    typedef struct packed {
        logic [1:0] kind;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic clk;
    logic reset;
    logic [15:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [15:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    step_t steps[$];
    step_t s;
    logic [31:0] rd;
    int errors;
    int checks;
    int cycles;
    int limit;
    int n_wait;

    vdp_copper_top #(
        .h_total(h_total),
        .v_total(v_total)
    ) uut (
        .clk(clk),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready)
    );

    `include "copper_tb_axil.svh"

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] reg_addr_of(input int idx);
        return dreg_base + 16'(idx * 4);
    endfunction

    function automatic logic [15:0] prog_addr_of(input int idx);
        return prog_base + 16'(idx * 4);
    endfunction

    // op in the top three bits, operand below
    function automatic logic [15:0] op_word(input logic [2:0] op, input logic [12:0] field);
        return {op, field};
    endfunction

    task automatic add_write(input logic [15:0] addr, input logic [31:0] data);
        steps.push_back('{k_write, addr, data, 32'h0});
    endtask

    task automatic add_check(input logic [15:0] addr, input logic [31:0] mask,
                             input logic [31:0] exp);
        steps.push_back('{k_check, addr, mask, exp});
    endtask

    task automatic add_wait_y(input int lo, input int hi);
        steps.push_back('{k_wait_y, 16'h0, 32'(lo), 32'(hi)});
        n_wait++;
    endtask

    task automatic add_prog_word(input int idx, input logic [15:0] word);
        add_write(prog_addr_of(idx), 32'(word));
        add_check(prog_addr_of(idx), full_mask, 32'(word));
    endtask

    task automatic wait_raster_y(input logic [y_bits-1:0] lo, input logic [y_bits-1:0] hi);
        logic [31:0] st;
        logic [y_bits-1:0] y;
        do begin
            axil_read(status_addr, st);
            y = st[stat_y_lsb +: y_bits];
        end while (y < lo || y > hi);
    endtask

    task automatic build_table();
        int i;
        // readback while disabled
        add_check(status_addr, 32'h3, 32'h0);
        add_write(ctrl_addr, 32'h0);
        add_check(ctrl_addr, full_mask, 32'h0);
        add_prog_word(0, op_word(op_write_reg, 13'd10));
        add_prog_word(1, 16'h1234);
        add_prog_word(2, op_word(op_write_reg, 13'd20));
        add_prog_word(3, 16'h5678);
        add_prog_word(4, op_word(op_halt, 13'd0));
        // run, then freeze once halted after a frame start
        add_write(ctrl_addr, 32'h1);
        add_check(ctrl_addr, full_mask, 32'h1);
        add_wait_y(v_total - 4, 1023);
        add_wait_y(1, 18);
        add_write(ctrl_addr, 32'h0);
        add_check(status_addr, 32'h3, 32'h2);
        add_check(reg_addr_of(10), full_mask, 32'h1234);
        add_check(reg_addr_of(20), full_mask, 32'h5678);
        add_check(reg_addr_of(11), full_mask, 32'h0);
        add_check(reg_addr_of(19), full_mask, 32'h0);
        for (i = 0; i < 64; i += 7) begin
            add_check(reg_addr_of(i), full_mask, 32'h0);
        end
        // raster wait program takes over at the next frame start
        add_prog_word(0, op_word(op_set_x, 13'd5));
        add_prog_word(1, op_word(op_wait_y, 13'd20));
        add_prog_word(2, op_word(op_write_reg, 13'd3));
        add_prog_word(3, 16'habcd);
        add_prog_word(4, op_word(op_halt, 13'd0));
        add_write(ctrl_addr, 32'h1);
        add_wait_y(21, 1023);
        add_wait_y(0, 18);
        add_check(status_addr, 32'h3, 32'h1);
        add_check(reg_addr_of(3), full_mask, 32'h0);
        add_wait_y(21, 1023);
        add_check(reg_addr_of(3), full_mask, 32'habcd);
        add_check(status_addr, 32'h3, 32'h2);
        // host value replaced again after the next frame
        add_write(reg_addr_of(3), 32'h1111);
        add_check(reg_addr_of(3), full_mask, 32'h1111);
        add_wait_y(0, 18);
        add_wait_y(21, 1023);
        add_check(reg_addr_of(3), full_mask, 32'habcd);
        // disabled engine leaves the host value alone
        add_write(ctrl_addr, 32'h0);
        add_check(ctrl_addr, full_mask, 32'h0);
        add_check(status_addr, 32'h3, 32'h2);
        add_write(reg_addr_of(3), 32'h2222);
        add_wait_y(0, 18);
        // a running engine would be waiting early in the frame
        add_check(status_addr, 32'h3, 32'h2);
        add_wait_y(21, 1023);
        add_check(reg_addr_of(3), full_mask, 32'h2222);
        add_check(status_addr, 32'h3, 32'h2);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        n_wait = 0;
        build_table();
        // four frames per wait, 50 cycles per access
        limit = reset_cycles + n_wait * 4 * frame_cycles + (steps.size() - n_wait) * 50;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.kind)
                k_write: axil_write(s.addr, s.data);
                k_check: begin
                    axil_read(s.addr, rd);
                    checks++;
                    assert ((rd & s.data) == s.exp) else begin
                        errors++;
                        $display("ERR at %0t: addr %h expected %h actual %h",
                                 $time, s.addr, s.exp, rd & s.data);
                    end
                end
                default: wait_raster_y(s.data[y_bits-1:0], s.exp[y_bits-1:0]);
            endcase
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+test
source/copper_pkg.sv
source/copper_reg_if.sv
source/raster_counter.sv
source/copper_ram.sv
source/copper_engine.sv
source/display_reg_file.sv
source/copper_axil_regs.sv
source/vdp_copper_top.sv
test/copper_tb.sv
